// ==== compile.f ====
src/soc_bus_pkg.sv
src/wb_if.sv
src/dev_if.sv
src/wb_pri_arbiter.sv
src/bus_decoder.sv
src/sys_info_regs.sv
src/switch_led_regs.sv
src/soc_bus_top.sv
dv/soc_bus_tb.sv

// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - files:
      - src/soc_bus_pkg.sv
      - src/wb_if.sv
      - src/dev_if.sv
      - src/wb_pri_arbiter.sv
      - src/bus_decoder.sv
      - src/sys_info_regs.sv
      - src/switch_led_regs.sv
      - src/soc_bus_top.sv
  - target: simulation
    files:
      - dv/soc_bus_tb.sv

// ==== dv/soc_bus_tb.sv ====
`timescale 1ns/1ps

module soc_bus_tb;
    import soc_bus_pkg::*;

    localparam int PERIOD  = 4;
    localparam int TIMEOUT = 50;
    localparam int MAX_REQ = 4;

    logic        clk;
    logic        rst_n;
    logic  [1:0] cyc;
    logic  [1:0] stb;
    logic  [1:0] we;
    wadr_t [1:0] adr;
    word_t [1:0] dat_w;
    sel_t  [1:0] sel;
    logic  [1:0] stall;
    logic  [1:0] ack;
    logic  [1:0] err;
    word_t [1:0] dat_r;
    led_t        switches;
    led_t        leds;

    // request table per master, index 0 is master a
    logic  req_we  [2][MAX_REQ];
    wadr_t req_adr [2][MAX_REQ];
    word_t req_dat [2][MAX_REQ];
    sel_t  req_sel [2][MAX_REQ];
    word_t exp_dat [2][MAX_REQ];
    bit    exp_e   [2][MAX_REQ];
    word_t rsp_dat [2][MAX_REQ];
    bit    rsp_err [2][MAX_REQ];
    int    rsp_lat [2][MAX_REQ];
    int    acc_cnt [2][MAX_REQ];
    time   acc_time [2][MAX_REQ];
    time   done_time [2];
    int    stall_seen [2];

    // reference model state
    word_t m_scratch;
    logic  m_irq;
    led_t  m_leds;
    wadr_t m_err_adr;

    soc_bus_top UUT (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_a_cyc    (cyc[0]),
        .i_a_stb    (stb[0]),
        .i_a_we     (we[0]),
        .i_a_adr    (adr[0]),
        .i_a_dat_w  (dat_w[0]),
        .i_a_sel    (sel[0]),
        .o_a_stall  (stall[0]),
        .o_a_ack    (ack[0]),
        .o_a_err    (err[0]),
        .o_a_dat_r  (dat_r[0]),
        .i_b_cyc    (cyc[1]),
        .i_b_stb    (stb[1]),
        .i_b_we     (we[1]),
        .i_b_adr    (adr[1]),
        .i_b_dat_w  (dat_w[1]),
        .i_b_sel    (sel[1]),
        .o_b_stall  (stall[1]),
        .o_b_ack    (ack[1]),
        .o_b_err    (err[1]),
        .o_b_dat_r  (dat_r[1]),
        .i_switches (switches),
        .o_leds     (leds)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            fail_stop($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_leds(input string name, input led_t exp, input led_t act);
        if (exp !== act) begin
            fail_stop($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_err(input string name, input bit exp, input bit act);
        if (exp !== act) begin
            fail_stop($sformatf("ERROR %s expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic bit is_sys(input wadr_t a);
        return a[29:21] == SYS_INFO_BASE;
    endfunction

    function automatic bit is_mapped(input wadr_t a);
        return is_sys(a) || (a == SW_LED_ADDR);
    endfunction

    // random word address inside the system info block
    function automatic wadr_t sys_adr(input reg_ofs_t ofs);
        logic [16:0] mid;
        mid = 17'($urandom);
        return {SYS_INFO_BASE, mid, ofs};
    endfunction

    function automatic wadr_t rand_unmapped();
        wadr_t a;
        a = wadr_t'($urandom);
        while (is_mapped(a)) begin
            a = wadr_t'($urandom);
        end
        return a;
    endfunction

    // read value is taken before the write lands, as on the bus
    function automatic word_t model_read(input wadr_t a);
        if (a == SW_LED_ADDR) begin
            return {switches, m_leds};
        end
        if (!is_sys(a)) begin
            return '0;
        end
        case (reg_ofs_t'(a[3:0]))
            OFS_ID:      return SYS_ID;
            OFS_SCRATCH: return m_scratch;
            OFS_BUSERR:  return word_t'(m_err_adr) * 4;
            OFS_IRQ:     return {31'd0, m_irq};
            default:     return '0;
        endcase
    endfunction

    task automatic queue_req(input int side, input int i, input logic w, input wadr_t a,
                             input word_t d, input sel_t s);
        req_we[side][i]  = w;
        req_adr[side][i] = a;
        req_dat[side][i] = d;
        req_sel[side][i] = s;
        exp_dat[side][i] = model_read(a);
        exp_e[side][i]   = !is_mapped(a);
        if (!is_mapped(a)) begin
            m_err_adr = a;
        end else if (w && a == SW_LED_ADDR) begin
            if (s[0]) m_leds[7:0] = d[7:0];
            if (s[1]) m_leds[15:8] = d[15:8];
        end else if (w && a[3:0] == OFS_SCRATCH) begin
            m_scratch = d;
        end else if (w && a[3:0] == OFS_IRQ) begin
            m_irq = d[0];
        end
    endtask

    // pipelined master, strobes back to back until all n requests are answered
    task automatic run_master(input int side, input int n);
        int sent;
        int got;
        int cnt;
        int other;
        bit last;
        bit done;
        sent = 0;
        got = 0;
        cnt = 0;
        other = 1 - side;
        last = 0;
        done = 0;
        stall_seen[side] = 0;
        while (!done) begin
            @(negedge clk);
            cnt++;
            if (ack[side] || err[side]) begin
                if (got >= sent) begin
                    fail_stop($sformatf("master %0d got a response it never asked for", side));
                end
                rsp_dat[side][got] = dat_r[side];
                rsp_err[side][got] = err[side];
                rsp_lat[side][got] = cnt - acc_cnt[side][got];
                got++;
            end
            // a master without cyc stays silent
            if (!cyc[other] && (ack[other] || err[other])) begin
                fail_stop($sformatf("idle master %0d got a bus response", other));
            end
            if (cnt > TIMEOUT) begin
                fail_stop($sformatf("master %0d timed out waiting for bus responses", side));
            end
            if (last) begin
                done_time[side] = $time;
                cyc[side] = 1'b0;
                stb[side] = 1'b0;
                done = 1;
            end else if (got == n) begin
                // cyc stays up through the edge that takes the last response
                stb[side] = 1'b0;
                last = 1;
            end else begin
                cyc[side] = 1'b1;
                stb[side] = (sent < n);
                if (sent < n) begin
                    we[side]    = req_we[side][sent];
                    adr[side]   = req_adr[side][sent];
                    dat_w[side] = req_dat[side][sent];
                    sel[side]   = req_sel[side][sent];
                end
                // stall settles after the drive, well before the rising edge
                #1;
                if (stall[side]) stall_seen[side]++;
                if (sent < n && !stall[side]) begin
                    acc_cnt[side][sent]  = cnt;
                    acc_time[side][sent] = $time;
                    sent++;
                end
            end
        end
    endtask

    task automatic check_resp(input string name, input int side, input int i, input bit cmp);
        check_err({name, " err"}, exp_e[side][i], rsp_err[side][i]);
        check_word({name, " latency"}, exp_e[side][i] ? 1 : 2, rsp_lat[side][i]);
        if (cmp && !req_we[side][i] && !exp_e[side][i]) begin
            check_word({name, " data"}, exp_dat[side][i], rsp_dat[side][i]);
        end
    endtask

    task automatic do_access(input string name, input int side, input logic w, input wadr_t a,
                             input word_t d, input sel_t s, input bit cmp);
        queue_req(side, 0, w, a, d, s);
        run_master(side, 1);
        check_resp(name, side, 0, cmp);
    endtask

    initial begin
        wadr_t a;
        word_t c1;
        time   t1;
        void'($urandom(32'hecaf));
        rst_n = 1'b0;
        cyc = '0;
        stb = '0;
        we = '0;
        adr = '0;
        dat_w = '0;
        sel = '0;
        switches = '0;
        m_scratch = '0;
        m_irq = 1'b0;
        m_leds = '0;
        m_err_adr = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_leds("leds after reset", '0, leds);
        check_err("responses after reset", 1'b0, |{ack, err, stall});

        do_access("id read a", 0, 1'b0, sys_adr(OFS_ID), '0, '0, 1);
        do_access("id read b", 1, 1'b0, sys_adr(OFS_ID), '0, '0, 1);
        do_access("unused offset", 0, 1'b0, sys_adr(reg_ofs_t'(5 + $urandom % 11)), '0, '0, 1);

        // scratch and irq flag with random byte selects
        for (int i = 0; i < 16; i++) begin
            a = sys_adr(($urandom % 2) ? OFS_SCRATCH : OFS_IRQ);
            do_access("reg write", $urandom % 2, 1'b1, a, $urandom, sel_t'($urandom), 0);
            do_access("reg readback", $urandom % 2, 1'b0, a, '0, '0, 1);
        end

        for (int i = 0; i < 6; i++) begin
            do_access("unmapped", $urandom % 2, $urandom % 2, rand_unmapped(), $urandom,
                      sel_t'($urandom), 0);
            @(negedge clk);
            check_err("no ack after err", 1'b0, ack[0] || ack[1]);
            do_access("buserr read", $urandom % 2, 1'b0, sys_adr(OFS_BUSERR), '0, '0, 1);
        end

        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            switches = led_t'($urandom);
            do_access("led write", $urandom % 2, 1'b1, SW_LED_ADDR, $urandom,
                      sel_t'($urandom), 0);
            check_leds("led output", m_leds, leds);
            do_access("led read", $urandom % 2, 1'b0, SW_LED_ADDR, '0, '0, 1);
        end

        // both masters start together, a keeps the bus until its cyc drops
        queue_req(0, 0, 1'b1, sys_adr(OFS_SCRATCH), $urandom, sel_t'($urandom));
        queue_req(0, 1, 1'b0, sys_adr(OFS_ID), '0, '0);
        queue_req(0, 2, 1'b0, sys_adr(OFS_SCRATCH), '0, '0);
        queue_req(1, 0, 1'b0, sys_adr(OFS_SCRATCH), '0, '0);
        queue_req(1, 1, 1'b1, SW_LED_ADDR, $urandom, sel_t'($urandom));
        fork
            run_master(0, 3);
            run_master(1, 2);
        join
        for (int i = 0; i < 3; i++) begin
            check_resp("contention a", 0, i, 1);
        end
        for (int i = 0; i < 2; i++) begin
            check_resp("contention b", 1, i, 1);
        end
        check_err("b stalled while a owns", 1'b1, stall_seen[1] > 0);
        check_err("b served after a", 1'b1, acc_time[1][0] > done_time[0]);
        check_leds("led after contention", m_leds, leds);

        do_access("counter first", 0, 1'b0, sys_adr(OFS_COUNTER), '0, '0, 0);
        c1 = rsp_dat[0][0];
        t1 = acc_time[0][0];
        repeat (1 + $urandom % 40) @(negedge clk);
        do_access("counter second", 1, 1'b0, sys_adr(OFS_COUNTER), '0, '0, 0);
        check_err("counter advance", 1'b1,
                  (rsp_dat[1][0] - c1) >= word_t'((acc_time[1][0] - t1) / PERIOD));

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== src/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top (
    input  logic               i_clk,
    input  logic               i_rst_n,
    // master a
    input  logic               i_a_cyc,
    input  logic               i_a_stb,
    input  logic               i_a_we,
    input  soc_bus_pkg::wadr_t i_a_adr,
    input  soc_bus_pkg::word_t i_a_dat_w,
    input  soc_bus_pkg::sel_t  i_a_sel,
    output logic               o_a_stall,
    output logic               o_a_ack,
    output logic               o_a_err,
    output soc_bus_pkg::word_t o_a_dat_r,
    // master b
    input  logic               i_b_cyc,
    input  logic               i_b_stb,
    input  logic               i_b_we,
    input  soc_bus_pkg::wadr_t i_b_adr,
    input  soc_bus_pkg::word_t i_b_dat_w,
    input  soc_bus_pkg::sel_t  i_b_sel,
    output logic               o_b_stall,
    output logic               o_b_ack,
    output logic               o_b_err,
    output soc_bus_pkg::word_t o_b_dat_r,
    // board io
    input  soc_bus_pkg::led_t  i_switches,
    output soc_bus_pkg::led_t  o_leds
);
    import soc_bus_pkg::*;

    wb_if  bus ();
    dev_if sys_dev ();
    dev_if led_dev ();

    logic  err_valid;
    wadr_t err_adr;

    wb_pri_arbiter u_arbiter (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_a_cyc   (i_a_cyc),
        .i_a_stb   (i_a_stb),
        .i_a_we    (i_a_we),
        .i_a_adr   (i_a_adr),
        .i_a_dat_w (i_a_dat_w),
        .i_a_sel   (i_a_sel),
        .o_a_stall (o_a_stall),
        .o_a_ack   (o_a_ack),
        .o_a_err   (o_a_err),
        .o_a_dat_r (o_a_dat_r),
        .i_b_cyc   (i_b_cyc),
        .i_b_stb   (i_b_stb),
        .i_b_we    (i_b_we),
        .i_b_adr   (i_b_adr),
        .i_b_dat_w (i_b_dat_w),
        .i_b_sel   (i_b_sel),
        .o_b_stall (o_b_stall),
        .o_b_ack   (o_b_ack),
        .o_b_err   (o_b_err),
        .o_b_dat_r (o_b_dat_r),
        .o_bus     (bus.master)
    );

    bus_decoder u_decoder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_bus       (bus.slave),
        .sys_dev     (sys_dev.master),
        .led_dev     (led_dev.master),
        .o_err_valid (err_valid),
        .o_err_adr   (err_adr)
    );

    sys_info_regs u_sys_info (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .dev         (sys_dev.slave),
        .i_err_valid (err_valid),
        .i_err_adr   (err_adr)
    );

    switch_led_regs u_switch_led (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .dev        (led_dev.slave),
        .i_switches (i_switches),
        .o_leds     (o_leds)
    );

endmodule

// ==== src/switch_led_regs.sv ====
`timescale 1ns/1ps

module switch_led_regs (
    input  logic              i_clk,
    input  logic              i_rst_n,
    dev_if.slave              dev,
    input  soc_bus_pkg::led_t i_switches,
    output soc_bus_pkg::led_t o_leds
);

    // led bytes follow the low two byte selects
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            dev.ack <= 1'b0;
            o_leds  <= '0;
        end else begin
            dev.ack <= dev.stb;
            if (dev.stb && dev.we) begin
                if (dev.sel[0]) begin
                    o_leds[7:0] <= dev.dat_w[7:0];
                end
                if (dev.sel[1]) begin
                    o_leds[15:8] <= dev.dat_w[15:8];
                end
            end
        end
    end

    // switches high, leds low
    always_ff @(posedge i_clk) begin
        if (dev.stb) begin
            dev.dat_r <= {i_switches, o_leds};
        end
    end

endmodule

// ==== src/sys_info_regs.sv ====
`timescale 1ns/1ps

module sys_info_regs (
    input  logic               i_clk,
    input  logic               i_rst_n,
    dev_if.slave               dev,
    input  logic               i_err_valid,
    input  soc_bus_pkg::wadr_t i_err_adr
);
    import soc_bus_pkg::*;

    word_t scratch_q;
    word_t counter_q;
    wadr_t err_adr_q;
    logic  irq_q;

    // registers, byte selects play no part here
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            dev.ack   <= 1'b0;
            scratch_q <= '0;
            irq_q     <= 1'b0;
            err_adr_q <= '0;
        end else begin
            dev.ack <= dev.stb;
            if (dev.stb && dev.we && dev.ofs == OFS_SCRATCH) begin
                scratch_q <= dev.dat_w;
            end
            if (dev.stb && dev.we && dev.ofs == OFS_IRQ) begin
                irq_q <= dev.dat_w[0];
            end
            if (i_err_valid) begin
                err_adr_q <= i_err_adr;
            end
        end
    end

    // power-on counter, top bit is sticky once reached
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            counter_q <= '0;
        end else if (!counter_q[31]) begin
            counter_q <= counter_q + 32'd1;
        end else begin
            counter_q[30:0] <= counter_q[30:0] + 31'd1;
        end
    end

    // read data captured on every strobe, held until the next one
    always_ff @(posedge i_clk) begin
        if (dev.stb) begin
            case (dev.ofs)
                OFS_ID:      dev.dat_r <= SYS_ID;
                OFS_SCRATCH: dev.dat_r <= scratch_q;
                OFS_BUSERR:  dev.dat_r <= {err_adr_q, 2'b00};
                OFS_COUNTER: dev.dat_r <= counter_q;
                OFS_IRQ:     dev.dat_r <= {31'd0, irq_q};
                default:     dev.dat_r <= '0;
            endcase
        end
    end

endmodule

// ==== src/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder (
    input  logic               i_clk,
    input  logic               i_rst_n,
    wb_if.slave                i_bus,
    dev_if.master              sys_dev,
    dev_if.master              led_dev,
    // bus error report to the system info block
    output logic               o_err_valid,
    output soc_bus_pkg::wadr_t o_err_adr
);
    import soc_bus_pkg::*;

    logic req;
    logic sys_hit;
    logic led_hit;
    logic err_q;

    assign req     = i_bus.cyc && i_bus.stb;
    assign sys_hit = (i_bus.adr[29:21] == SYS_INFO_BASE);
    assign led_hit = (i_bus.adr == SW_LED_ADDR);

    // strobe goes straight through to the claiming slave
    assign sys_dev.stb   = req && sys_hit;
    assign sys_dev.we    = i_bus.we;
    assign sys_dev.ofs   = i_bus.adr[3:0];
    assign sys_dev.dat_w = i_bus.dat_w;
    assign sys_dev.sel   = i_bus.sel;

    assign led_dev.stb   = req && led_hit;
    assign led_dev.we    = i_bus.we;
    assign led_dev.ofs   = i_bus.adr[3:0];
    assign led_dev.dat_w = i_bus.dat_w;
    assign led_dev.sel   = i_bus.sel;

    // ack and err back to the master, one register stage
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            i_bus.ack <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            i_bus.ack <= sys_dev.ack || led_dev.ack;
            err_q     <= req && !sys_hit && !led_hit;
        end
    end

    // data of whichever slave acked, zero otherwise
    always_ff @(posedge i_clk) begin
        if (sys_dev.ack) begin
            i_bus.dat_r <= sys_dev.dat_r;
        end else if (led_dev.ack) begin
            i_bus.dat_r <= led_dev.dat_r;
        end else begin
            i_bus.dat_r <= '0;
        end
    end

    // word address of the unclaimed request, lined up with err
    always_ff @(posedge i_clk) begin
        if (req && !sys_hit && !led_hit) begin
            o_err_adr <= i_bus.adr;
        end
    end

    assign i_bus.err   = err_q;
    assign o_err_valid = err_q;

endmodule

// ==== src/wb_pri_arbiter.sv ====
`timescale 1ns/1ps

module wb_pri_arbiter (
    input  logic               i_clk,
    input  logic               i_rst_n,
    // master a, the high priority side
    input  logic               i_a_cyc,
    input  logic               i_a_stb,
    input  logic               i_a_we,
    input  soc_bus_pkg::wadr_t i_a_adr,
    input  soc_bus_pkg::word_t i_a_dat_w,
    input  soc_bus_pkg::sel_t  i_a_sel,
    output logic               o_a_stall,
    output logic               o_a_ack,
    output logic               o_a_err,
    output soc_bus_pkg::word_t o_a_dat_r,
    // master b
    input  logic               i_b_cyc,
    input  logic               i_b_stb,
    input  logic               i_b_we,
    input  soc_bus_pkg::wadr_t i_b_adr,
    input  soc_bus_pkg::word_t i_b_dat_w,
    input  soc_bus_pkg::sel_t  i_b_sel,
    output logic               o_b_stall,
    output logic               o_b_ack,
    output logic               o_b_err,
    output soc_bus_pkg::word_t o_b_dat_r,
    // merged bus toward the decoder
    wb_if.master               o_bus
);
    import soc_bus_pkg::*;

    owner_e owner_q;
    owner_e owner;
    logic   owner_cyc;

    // ownership moves only while the current owner is idle
    // an idle bus rests with a, so a wins a tie
    always_comb begin
        owner_cyc = (owner_q == OWN_A) ? i_a_cyc : i_b_cyc;
        owner     = owner_q;
        if (!owner_cyc) begin
            owner = (i_b_cyc && !i_a_cyc) ? OWN_B : OWN_A;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            owner_q <= OWN_A;
        end else begin
            owner_q <= owner;
        end
    end

    // request mux
    always_comb begin
        if (owner == OWN_A) begin
            o_bus.cyc   = i_a_cyc;
            o_bus.stb   = i_a_stb;
            o_bus.we    = i_a_we;
            o_bus.adr   = i_a_adr;
            o_bus.dat_w = i_a_dat_w;
            o_bus.sel   = i_a_sel;
        end else begin
            o_bus.cyc   = i_b_cyc;
            o_bus.stb   = i_b_stb;
            o_bus.we    = i_b_we;
            o_bus.adr   = i_b_adr;
            o_bus.dat_w = i_b_dat_w;
            o_bus.sel   = i_b_sel;
        end
    end

    // the waiting master is held off, responses go to the owner only
    assign o_a_stall = (owner == OWN_B) && i_a_stb;
    assign o_b_stall = (owner == OWN_A) && i_b_stb;
    assign o_a_ack   = (owner == OWN_A) && o_bus.ack;
    assign o_b_ack   = (owner == OWN_B) && o_bus.ack;
    assign o_a_err   = (owner == OWN_A) && o_bus.err;
    assign o_b_err   = (owner == OWN_B) && o_bus.err;

    // read data is shared
    assign o_a_dat_r = o_bus.dat_r;
    assign o_b_dat_r = o_bus.dat_r;

endmodule

// ==== src/dev_if.sv ====
`timescale 1ns/1ps

interface dev_if;
    import soc_bus_pkg::*;

    logic     stb;
    logic     we;
    reg_ofs_t ofs;
    word_t    dat_w;
    sel_t     sel;

    // ack one cycle after stb, dat_r held until the next stb
    logic     ack;
    word_t    dat_r;

    modport master (
        output stb, we, ofs, dat_w, sel,
        input  ack, dat_r
    );

    modport slave (
        input  stb, we, ofs, dat_w, sel,
        output ack, dat_r
    );

endinterface

// ==== src/wb_if.sv ====
`timescale 1ns/1ps

interface wb_if;
    import soc_bus_pkg::*;

    // request side
    logic  cyc;
    logic  stb;
    logic  we;
    wadr_t adr;
    word_t dat_w;
    sel_t  sel;

    // response side, no stall since no slave ever stalls
    logic  ack;
    logic  err;
    word_t dat_r;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  ack, err, dat_r
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output ack, err, dat_r
    );

endinterface

// ==== src/soc_bus_pkg.sv ====
package soc_bus_pkg;

    // bus payload widths
    typedef logic [31:0] word_t;
    typedef logic [29:0] wadr_t;
    typedef logic [3:0]  sel_t;

    // low word-address bits seen by a slave
    typedef logic [3:0]  reg_ofs_t;

    // switch and led vectors
    typedef logic [15:0] led_t;

    // arbiter bus owner
    typedef enum logic {
        OWN_A,
        OWN_B
    } owner_e;

    // memory map
    // system info claims every word address whose top nine bits are all ones
    localparam logic [8:0] SYS_INFO_BASE = 9'h1ff;
    localparam wadr_t      SW_LED_ADDR   = 30'h400001;

    // identification word of the system info block
    localparam word_t SYS_ID = 32'h20191028;

    // system info register offsets
    localparam reg_ofs_t OFS_ID      = 4'h0;
    localparam reg_ofs_t OFS_SCRATCH = 4'h1;
    localparam reg_ofs_t OFS_BUSERR  = 4'h2;
    localparam reg_ofs_t OFS_COUNTER = 4'h3;
    localparam reg_ofs_t OFS_IRQ     = 4'h4;

endpackage
